//--- common/mem_pkg.sv
package mem_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [4:0] reg_addr_t;

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } mem_size_e;

  typedef enum logic [1:0] {
    MEM_NONE  = 2'b00,
    MEM_LOAD  = 2'b01,
    MEM_STORE = 2'b10
  } mem_op_e;

  // one data word, seen as byte lanes or as halfword lanes
  typedef union packed {
    logic [3:0][7:0] bytes;
    logic [1:0][15:0] halves;
  } data_word_u;

  // lane 0 may carry a load or store
  typedef struct packed {
    logic valid;
    mem_op_e mem_op;
    mem_size_e size;
    logic is_unsigned;
    xlen_t address;
    xlen_t sdata;
    logic wren;
    reg_addr_t waddr;
    xlen_t wdata;
  } lane0_instr_t;

  // register result of one lane
  typedef struct packed {
    logic valid;
    logic wren;
    reg_addr_t waddr;
    xlen_t wdata;
  } result_t;

  typedef result_t lane1_instr_t;

  typedef struct packed {
    logic req;
    xlen_t addr;
    xlen_t wdata;
    logic [3:0] wstrb;
  } dmem_req_t;

  typedef struct packed {
    logic ready;
    xlen_t rdata;
  } dmem_rsp_t;

  typedef struct packed {
    logic wren;
    reg_addr_t waddr;
    xlen_t wdata;
  } fwd_t;

  typedef struct packed {
    result_t lane0;
    result_t lane1;
    logic stall;
  } wb_t;

endpackage

//--- memory_stage/lsu.sv
`timescale 1ns/1ps

module lsu (
  input mem_pkg::xlen_t sdata,
  input mem_pkg::mem_size_e size,
  input logic is_unsigned,
  input logic [1:0] offset,
  input mem_pkg::xlen_t rdata,
  output mem_pkg::xlen_t wdata,
  output logic [3:0] wstrb,
  output mem_pkg::xlen_t result
);
  import mem_pkg::*;

  data_word_u store_word;
  data_word_u load_word;
  logic [7:0] lane_byte;
  logic [15:0] lane_half;

  // store side, replicate onto every lane and let the strobes pick
  always_comb begin
    store_word.bytes = sdata;
    wstrb = 4'hf;
    case (size)
      SIZE_BYTE: begin
        store_word.bytes = {4{sdata[7:0]}};
        wstrb = 4'b0001 << offset;
      end
      SIZE_HALF: begin
        store_word.halves = {2{sdata[15:0]}};
        wstrb = offset[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        store_word.bytes = sdata;
        wstrb = 4'hf;
      end
    endcase
    wdata = store_word;
  end

  // load side
  always_comb begin
    load_word.bytes = rdata;
    lane_byte = load_word.bytes[offset];
    lane_half = load_word.halves[offset[1]];
    case (size)
      SIZE_BYTE: begin
        result = {{24{lane_byte[7] & ~is_unsigned}}, lane_byte};
      end
      SIZE_HALF: begin
        result = {{16{lane_half[15] & ~is_unsigned}}, lane_half};
      end
      default: begin
        result = rdata;
      end
    endcase
  end

endmodule

//--- memory_stage/memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
  input logic clock,
  input logic reset,
  input logic flush,
  input mem_pkg::lane0_instr_t exec0,
  input mem_pkg::lane1_instr_t exec1,
  output mem_pkg::dmem_req_t dmem_req,
  input mem_pkg::dmem_rsp_t dmem_rsp,
  input mem_pkg::xlen_t lsu_wdata,
  input logic [3:0] lsu_wstrb,
  input mem_pkg::xlen_t lsu_result,
  output mem_pkg::xlen_t lsu_sdata,
  output mem_pkg::mem_size_e lsu_size,
  output logic lsu_unsigned,
  output logic [1:0] lsu_offset,
  output mem_pkg::fwd_t fwd0,
  output mem_pkg::fwd_t fwd1,
  output logic stall,
  output mem_pkg::wb_t wb
);
  import mem_pkg::*;

  wb_t r;
  wb_t rin;
  wb_t v;

  logic is_load;
  logic is_store;
  logic mem_valid;

  always_comb begin
    is_load = exec0.valid & (exec0.mem_op == MEM_LOAD);
    is_store = exec0.valid & (exec0.mem_op == MEM_STORE);
    mem_valid = is_load | is_store;

    lsu_sdata = exec0.sdata;
    lsu_size = exec0.size;
    lsu_unsigned = exec0.is_unsigned;
    lsu_offset = exec0.address[1:0];

    // request comes straight from the packet in the stage
    dmem_req.req = mem_valid & ~flush;
    dmem_req.addr = exec0.address;
    dmem_req.wdata = lsu_wdata;
    dmem_req.wstrb = is_store ? lsu_wstrb : 4'h0;

    v.lane0.valid = exec0.valid;
    v.lane0.wren = exec0.wren;
    v.lane0.waddr = exec0.waddr;
    v.lane0.wdata = is_load ? lsu_result : exec0.wdata;
    v.lane1 = exec1;

    v.stall = mem_valid & ~flush & ~dmem_rsp.ready;

    // a held or killed pair must not reach writeback
    if ((v.stall | flush) == 1) begin
      v.lane0 = '0;
      v.lane1 = '0;
    end

    fwd0.wren = v.lane0.valid & v.lane0.wren;
    fwd0.waddr = v.lane0.waddr;
    fwd0.wdata = v.lane0.wdata;

    fwd1.wren = v.lane1.valid & v.lane1.wren;
    fwd1.waddr = v.lane1.waddr;
    fwd1.wdata = v.lane1.wdata;

    stall = v.stall;
    rin = v;
  end

  assign wb = r;

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      r.lane0.valid <= 0;
      r.lane0.wren <= 0;
      r.lane1.valid <= 0;
      r.lane1.wren <= 0;
      r.stall <= 0;
    end else begin
      r <= rin;
    end
  end

  // the source holds lane 0 while the access is pending
  assert property (@(posedge clock) disable iff (reset == 0)
    stall |=> $stable(exec0));

  // lsu lane logic assumes natural alignment
  assert property (@(posedge clock) disable iff (reset == 0)
    dmem_req.req |-> ((exec0.size == SIZE_BYTE) ||
                      (exec0.size == SIZE_HALF && exec0.address[0] == 1'b0) ||
                      (exec0.address[1:0] == 2'b00)));

endmodule

//--- verilog/dtim.sv
`timescale 1ns/1ps

module dtim #(
  parameter int DEPTH_LOG2 = 8,
  parameter int MAX_WAIT = 3
) (
  input logic clock,
  input logic reset,
  input mem_pkg::dmem_req_t dmem_req,
  output mem_pkg::dmem_rsp_t dmem_rsp
);
  import mem_pkg::*;

  localparam int WAIT_W = (MAX_WAIT > 0) ? $clog2(MAX_WAIT + 1) : 1;

  xlen_t mem [2**DEPTH_LOG2];

  logic [DEPTH_LOG2-1:0] index;
  logic [15:0] lfsr;
  logic busy;
  logic [WAIT_W-1:0] count;
  logic [WAIT_W-1:0] new_wait;
  logic ready;

  assign index = dmem_req.addr[DEPTH_LOG2+1:2];
  assign new_wait = WAIT_W'(lfsr % (MAX_WAIT + 1));

  // zero wait states completes in the cycle the request shows up
  assign ready = dmem_req.req & (busy ? (count == '0) : (new_wait == '0));

  assign dmem_rsp.ready = ready;
  assign dmem_rsp.rdata = mem[index];

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      lfsr <= 16'hace1;
      busy <= 0;
      count <= '0;
    end else begin
      // x^16 + x^14 + x^13 + x^11 + 1
      lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      if (dmem_req.req == 0 || ready == 1) begin
        busy <= 0;
      end else if (busy == 0) begin
        busy <= 1;
        count <= new_wait - 1'b1;
      end else begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (ready == 1) begin
      for (int i = 0; i < 4; i++) begin
        if (dmem_req.wstrb[i] == 1) begin
          mem[index][8*i +: 8] <= dmem_req.wdata[8*i +: 8];
        end
      end
    end
  end

endmodule

//--- verilog/memory_top.sv
`timescale 1ns/1ps

module memory_top #(
  parameter int DEPTH_LOG2 = 8,
  parameter int MAX_WAIT = 3
) (
  input logic clock,
  input logic reset,
  input logic flush,
  input mem_pkg::lane0_instr_t exec0,
  input mem_pkg::lane1_instr_t exec1,
  output logic stall,
  output mem_pkg::fwd_t fwd0,
  output mem_pkg::fwd_t fwd1,
  output mem_pkg::wb_t wb
);
  import mem_pkg::*;

  dmem_req_t dmem_req;
  dmem_rsp_t dmem_rsp;

  xlen_t lsu_sdata;
  mem_size_e lsu_size;
  logic lsu_unsigned;
  logic [1:0] lsu_offset;
  xlen_t lsu_wdata;
  logic [3:0] lsu_wstrb;
  xlen_t lsu_result;

  memory_stage memory_stage_0 (
    .clock(clock),
    .reset(reset),
    .flush(flush),
    .exec0(exec0),
    .exec1(exec1),
    .dmem_req(dmem_req),
    .dmem_rsp(dmem_rsp),
    .lsu_wdata(lsu_wdata),
    .lsu_wstrb(lsu_wstrb),
    .lsu_result(lsu_result),
    .lsu_sdata(lsu_sdata),
    .lsu_size(lsu_size),
    .lsu_unsigned(lsu_unsigned),
    .lsu_offset(lsu_offset),
    .fwd0(fwd0),
    .fwd1(fwd1),
    .stall(stall),
    .wb(wb)
  );

  // load data goes straight from the dtim into the lsu
  lsu lsu_0 (
    .sdata(lsu_sdata),
    .size(lsu_size),
    .is_unsigned(lsu_unsigned),
    .offset(lsu_offset),
    .rdata(dmem_rsp.rdata),
    .wdata(lsu_wdata),
    .wstrb(lsu_wstrb),
    .result(lsu_result)
  );

  dtim #(
    .DEPTH_LOG2(DEPTH_LOG2),
    .MAX_WAIT(MAX_WAIT)
  ) dtim_0 (
    .clock(clock),
    .reset(reset),
    .dmem_req(dmem_req),
    .dmem_rsp(dmem_rsp)
  );

endmodule

//--- bench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
  parameter int PERIOD = 20,
  parameter int RESET_CYCLES = 5
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  // release a little after the last reset edge
  initial begin
    reset = 0;
    repeat (RESET_CYCLES) @(posedge clock);
    #2;
    reset = 1;
  end

endmodule

//--- bench/wb_checker.sv
`timescale 1ns/1ps

module wb_checker #(
  parameter int MAX_WAIT = 3
) (
  input logic clock,
  input logic reset,
  input logic flush,
  input mem_pkg::lane0_instr_t exec0,
  input mem_pkg::lane1_instr_t exec1,
  input logic stall,
  input mem_pkg::fwd_t fwd0,
  input mem_pkg::fwd_t fwd1,
  input mem_pkg::wb_t wb,
  output int errors,
  output int checks
);
  import mem_pkg::*;

  // byte model of the 64 test words
  logic [7:0] model_mem [256];
  wb_t expected;
  logic have_expect = 0;
  int stall_run = 0;
  int err_count = 0;
  int check_count = 0;

  assign errors = err_count;
  assign checks = check_count;

  function automatic xlen_t load_value(input lane0_instr_t i);
    logic [7:0] a;
    xlen_t value;
    a = i.address[7:0];
    case (i.size)
      SIZE_BYTE: begin
        value = {24'h0, model_mem[a]};
        if (!i.is_unsigned && value[7]) begin
          value = value | 32'hffff_ff00;
        end
      end
      SIZE_HALF: begin
        value = {16'h0, model_mem[a + 8'd1], model_mem[a]};
        if (!i.is_unsigned && value[15]) begin
          value = value | 32'hffff_0000;
        end
      end
      default: begin
        value = {model_mem[a + 8'd3], model_mem[a + 8'd2], model_mem[a + 8'd1], model_mem[a]};
      end
    endcase
    return value;
  endfunction

  task automatic store_bytes(input lane0_instr_t i);
    int n;
    n = (i.size == SIZE_BYTE) ? 1 : ((i.size == SIZE_HALF) ? 2 : 4);
    for (int k = 0; k < n; k++) begin
      model_mem[i.address[7:0] + 8'(k)] = i.sdata[8*k +: 8];
    end
  endtask

  task automatic compare_lane(input string name, input result_t got, input result_t exp);
    check_count++;
    if (got.valid !== exp.valid || (exp.valid && (got.wren !== exp.wren ||
        got.waddr !== exp.waddr || got.wdata !== exp.wdata))) begin
      err_count++;
      $display("ERR %0t: wb %s is v=%b wr=%b x%0d=%h, expected v=%b wr=%b x%0d=%h", $time,
               name, got.valid, got.wren, got.waddr, got.wdata,
               exp.valid, exp.wren, exp.waddr, exp.wdata);
    end
  endtask

  // forwarding must match what gets registered at the next edge
  task automatic compare_fwd(input string name, input fwd_t got, input result_t exp);
    logic wr;
    wr = exp.valid & exp.wren;
    check_count++;
    if (got.wren !== wr || (wr && (got.waddr !== exp.waddr || got.wdata !== exp.wdata))) begin
      err_count++;
      $display("ERR %0t: %s is wr=%b x%0d=%h, expected wr=%b x%0d=%h", $time, name,
               got.wren, got.waddr, got.wdata, wr, exp.waddr, exp.wdata);
    end
  endtask

  always @(negedge clock) begin
    if (reset == 0) begin
      expected = '0;
      have_expect = 1;
      stall_run = 0;
    end else begin
      if (have_expect) begin
        compare_lane("lane0", wb.lane0, expected.lane0);
        compare_lane("lane1", wb.lane1, expected.lane1);
        check_count++;
        if (wb.stall !== expected.stall) begin
          err_count++;
          $display("ERR %0t: wb stall is %b, expected %b", $time, wb.stall, expected.stall);
        end
      end
      expected = '0;
      expected.stall = stall;
      if (stall !== 1'b0) begin
        stall_run++;
        check_count++;
        if (!(exec0.valid && exec0.mem_op != MEM_NONE && !flush)) begin
          err_count++;
          $display("ERR %0t: stall is %b with no pending memory access", $time, stall);
        end
        if (stall_run > MAX_WAIT) begin
          err_count++;
          $display("ERR %0t: stall held for %0d cycles, limit %0d", $time, stall_run, MAX_WAIT);
        end
      end else begin
        stall_run = 0;
        if (!flush) begin
          expected.lane0.valid = exec0.valid;
          expected.lane0.wren = exec0.wren;
          expected.lane0.waddr = exec0.waddr;
          expected.lane0.wdata = exec0.wdata;
          if (exec0.valid && exec0.mem_op == MEM_LOAD) begin
            expected.lane0.wdata = load_value(exec0);
          end
          if (exec0.valid && exec0.mem_op == MEM_STORE) begin
            store_bytes(exec0);
          end
          expected.lane1 = exec1;
        end
      end
      compare_fwd("fwd0", fwd0, expected.lane0);
      compare_fwd("fwd1", fwd1, expected.lane1);
    end
  end

endmodule

//--- bench/tb_top.sv
`timescale 1ns/1ps

module tb_top;
  import mem_pkg::*;

  localparam int DEPTH_LOG2 = 8;
  localparam int MAX_WAIT = 3;
  localparam int NUM_PAIRS = 2000;
  localparam int INIT_WORDS = 64;
  localparam int TIMEOUT = NUM_PAIRS * (MAX_WAIT + 2) + 100;

  logic clock;
  logic reset;
  logic flush;
  lane0_instr_t exec0;
  lane1_instr_t exec1;
  logic stall;
  fwd_t fwd0;
  fwd_t fwd1;
  wb_t wb;
  int errors;
  int checks;
  int seed;
  int accepted = 0;
  int cycles = 0;
  logic take;

  clock_gen clock_gen0 (
    .clock(clock),
    .reset(reset)
  );

  memory_top #(
    .DEPTH_LOG2(DEPTH_LOG2),
    .MAX_WAIT(MAX_WAIT)
  ) dut0 (
    .clock(clock),
    .reset(reset),
    .flush(flush),
    .exec0(exec0),
    .exec1(exec1),
    .stall(stall),
    .fwd0(fwd0),
    .fwd1(fwd1),
    .wb(wb)
  );

  wb_checker #(
    .MAX_WAIT(MAX_WAIT)
  ) checker0 (
    .clock(clock),
    .reset(reset),
    .flush(flush),
    .exec0(exec0),
    .exec1(exec1),
    .stall(stall),
    .fwd0(fwd0),
    .fwd1(fwd1),
    .wb(wb),
    .errors(errors),
    .checks(checks)
  );

  // first pairs fill the 64 test words, then a random mix
  task automatic draw_pair(input int n);
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    logic [31:0] r4;
    logic [1:0] off;
    r0 = $random(seed);
    r1 = $random(seed);
    r2 = $random(seed);
    r3 = $random(seed);
    r4 = $random(seed);
    exec0 = '0;
    exec0.valid = |r0[3:0];
    exec0.wren = r0[4] | r0[5];
    exec0.waddr = r0[10:6];
    exec0.wdata = r1;
    exec0.sdata = r2;
    exec0.is_unsigned = r0[15];
    case (r0[12:11])
      2'd0: exec0.mem_op = MEM_NONE;
      2'd3: exec0.mem_op = MEM_STORE;
      default: exec0.mem_op = MEM_LOAD;
    endcase
    case (r0[14:13])
      2'd0: begin
        exec0.size = SIZE_BYTE;
        off = r0[23:22];
      end
      2'd1: begin
        exec0.size = SIZE_HALF;
        off = {r0[23], 1'b0};
      end
      default: begin
        exec0.size = SIZE_WORD;
        off = 2'b00;
      end
    endcase
    exec0.address = {24'h0, r0[21:16], off};
    flush = (r0[27:24] == 4'h0);
    exec1.valid = r3[0] | r3[1];
    exec1.wren = r3[2];
    exec1.waddr = r3[7:3];
    exec1.wdata = r4;
    if (n < INIT_WORDS) begin
      exec0.valid = 1;
      exec0.mem_op = MEM_STORE;
      exec0.size = SIZE_WORD;
      exec0.address = {24'h0, n[5:0], 2'b00};
      flush = 0;
    end
  endtask

  initial begin
    seed = 32'hb23a_79ce;
    exec0 = '0;
    exec1 = '0;
    flush = 0;
    @(posedge reset);
    draw_pair(0);
    while (accepted < NUM_PAIRS) begin
      // stall is settled by the falling edge
      @(negedge clock);
      take = ~stall;
      @(posedge clock);
      #2;
      if (take == 1) begin
        accepted++;
        if (accepted < NUM_PAIRS) begin
          draw_pair(accepted);
        end else begin
          exec0 = '0;
          exec1 = '0;
          flush = 0;
        end
      end
    end
    repeat (3) @(negedge clock);
    $display("pairs: %0d, checks: %0d, errors: %0d", accepted, checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("run did not finish, only %0d of %0d pairs accepted after %0d cycles",
               accepted, NUM_PAIRS, cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

endmodule

//--- sim.f
common/mem_pkg.sv
memory_stage/lsu.sv
memory_stage/memory_stage.sv
verilog/dtim.sv
verilog/memory_top.sv
bench/clock_gen.sv
bench/wb_checker.sv
bench/tb_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_top
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TEST FAILED" $(LOG) || [ $$status -ne 0 ]; then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
